// ==== common/coreTypes_pkg.sv ====
`default_nettype none

package coreTypes_pkg;

        localparam int dataWidth    = 16;
        localparam int regAddrWidth = 3;
        localparam int opWidth      = 7;
        localparam int immWidth     = 6;
        localparam int numRegs      = 2 ** regAddrWidth;

        typedef enum logic [3:0] {
                aluAnd   = 4'd1,
                aluAdd   = 4'd2,
                aluOr    = 4'd3,
                aluSub   = 4'd5,
                aluPassB = 4'd12,
                aluXor   = 4'd13
        } aluOp_t;

        typedef enum logic [3:0] {
                bsNone = 4'd0,
                bsShl  = 4'd2,
                bsShr  = 4'd3,
                bsSra  = 4'd4,
                bsRol  = 4'd5
        } bsOp_t;

        typedef struct packed {
                aluOp_t aluOp;
                bsOp_t  bsOp;
                logic   regWrite;
                logic   immSel;    // operand B from immediate
                logic   immSigned;
                logic   enable;    // low only for halt
        } ctrlWord_t;

        typedef struct packed {
                logic [opWidth-1:0]      opcode;
                logic [regAddrWidth-1:0] rd;
                logic [regAddrWidth-1:0] rs;
                logic [regAddrWidth-1:0] rt;
        } instr_t;

        typedef struct packed {
                ctrlWord_t               ctrl;
                logic [regAddrWidth-1:0] rd;
                logic [regAddrWidth-1:0] rs;
                logic [regAddrWidth-1:0] rt;
                logic [immWidth-1:0]     imm;
                logic [dataWidth-1:0]    opA;
                logic [dataWidth-1:0]    opB;
        } execEntry_t;

        typedef struct packed {
                logic                    regWrite;
                logic [regAddrWidth-1:0] rd;
                logic [dataWidth-1:0]    result;
        } wbEntry_t;

        localparam logic [opWidth-1:0] opShlI  = 7'd1;
        localparam logic [opWidth-1:0] opShrI  = 7'd2;
        localparam logic [opWidth-1:0] opSraI  = 7'd3;
        localparam logic [opWidth-1:0] opAdd   = 7'd4;
        localparam logic [opWidth-1:0] opSub   = 7'd5;
        localparam logic [opWidth-1:0] opAddI  = 7'd6;
        localparam logic [opWidth-1:0] opSubI  = 7'd7;
        localparam logic [opWidth-1:0] opLoadI = 7'd8;
        localparam logic [opWidth-1:0] opCmp   = 7'd9;
        localparam logic [opWidth-1:0] opAddIS = 7'd10;
        localparam logic [opWidth-1:0] opOr    = 7'd12;
        localparam logic [opWidth-1:0] opXor   = 7'd13;
        localparam logic [opWidth-1:0] opShl   = 7'd14;
        localparam logic [opWidth-1:0] opShr   = 7'd15;
        localparam logic [opWidth-1:0] opSra   = 7'd16;
        localparam logic [opWidth-1:0] opAnd   = 7'd17;
        localparam logic [opWidth-1:0] opRol   = 7'd19;
        localparam logic [opWidth-1:0] opHalt  = 7'd75;

endpackage

`default_nettype wire

// ==== rtl/controlCore.sv ====
`default_nettype none

module controlCore (
        input  logic [coreTypes_pkg::opWidth-1:0] opcode,
        output coreTypes_pkg::ctrlWord_t          ctrl
);
        import coreTypes_pkg::*;

        always_comb begin
                // plain register write through the ALU unless told otherwise
                ctrl.aluOp     = aluPassB;
                ctrl.bsOp      = bsNone;
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = 1'b0;
                ctrl.immSigned = 1'b0;
                ctrl.enable    = 1'b1;

                case (opcode)
                        opShlI: begin
                                ctrl.bsOp   = bsShl;
                                ctrl.immSel = 1'b1;
                        end
                        opShrI: begin
                                ctrl.bsOp   = bsShr;
                                ctrl.immSel = 1'b1;
                        end
                        opSraI: begin
                                ctrl.bsOp   = bsSra;
                                ctrl.immSel = 1'b1;
                        end
                        opAdd: ctrl.aluOp = aluAdd;
                        opSub: ctrl.aluOp = aluSub;
                        opAddI: begin
                                ctrl.aluOp  = aluAdd;
                                ctrl.immSel = 1'b1;
                        end
                        opSubI: begin
                                ctrl.aluOp  = aluSub;
                                ctrl.immSel = 1'b1;
                        end
                        opLoadI: begin
                                ctrl.immSel = 1'b1;   // pass-B of the immediate
                        end
                        opCmp: begin
                                ctrl.aluOp    = aluSub;
                                ctrl.immSel   = 1'b1;
                                ctrl.regWrite = 1'b0;
                        end
                        opAddIS: begin
                                ctrl.aluOp     = aluAdd;
                                ctrl.immSel    = 1'b1;
                                ctrl.immSigned = 1'b1;
                        end
                        opOr:  ctrl.aluOp = aluOr;
                        opXor: ctrl.aluOp = aluXor;
                        opShl: ctrl.bsOp = bsShl;
                        opShr: ctrl.bsOp = bsShr;
                        opSra: ctrl.bsOp = bsSra;
                        opAnd: ctrl.aluOp = aluAnd;
                        opRol: ctrl.bsOp = bsRol;
                        opHalt: begin
                                ctrl.regWrite = 1'b0;
                                ctrl.enable   = 1'b0;
                        end
                        default: ctrl.regWrite = 1'b0;   // unknown op writes nothing
                endcase
        end

endmodule

`default_nettype wire

// ==== rtl/stageReg.sv ====
`default_nettype none

module stageReg #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     rstN,
        input  logic     load,
        input  payload_t dIn,
        output logic     valid,
        output payload_t q
);

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN)
                        valid <= 1'b0;
                else
                        valid <= load;   // bubble when nothing loads
        end

        always_ff @(posedge clk) begin
                if (load)
                        q <= dIn;
        end

endmodule

`default_nettype wire

// ==== rtl/regBank.sv ====
`default_nettype none

module regBank (
        input  logic                                   clk,
        input  logic                                   rstN,
        input  logic                                   wrEn,
        input  logic [coreTypes_pkg::regAddrWidth-1:0] wrAddr,
        input  logic [coreTypes_pkg::regAddrWidth-1:0] rdAddrA,
        input  logic [coreTypes_pkg::regAddrWidth-1:0] rdAddrB,
        input  logic [coreTypes_pkg::dataWidth-1:0]    wrData,
        output logic [coreTypes_pkg::dataWidth-1:0]    rdDataA,
        output logic [coreTypes_pkg::dataWidth-1:0]    rdDataB
);
        import coreTypes_pkg::*;

        logic [dataWidth-1:0] regs [numRegs];

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < numRegs; i++)
                                regs[i] <= '0;
                end else if (wrEn) begin
                        regs[wrAddr] <= wrData;
                end
        end

        // write-through so a read in the write cycle sees the new value
        always_comb begin
                if (wrEn && wrAddr == rdAddrA)
                        rdDataA = wrData;
                else
                        rdDataA = regs[rdAddrA];

                if (wrEn && wrAddr == rdAddrB)
                        rdDataB = wrData;
                else
                        rdDataB = regs[rdAddrB];
        end

endmodule

`default_nettype wire

// ==== rtl/execUnit/aluUnit.sv ====
`default_nettype none

module aluUnit (
        input  coreTypes_pkg::aluOp_t                aluOp,
        input  logic [coreTypes_pkg::dataWidth-1:0]  a,
        input  logic [coreTypes_pkg::dataWidth-1:0]  b,
        output logic [coreTypes_pkg::dataWidth-1:0]  y
);
        import coreTypes_pkg::*;

        always_comb begin
                case (aluOp)
                        aluAnd: begin
                                y = a & b;
                        end
                        aluAdd: begin
                                y = a + b;   // wraps on 16 bits
                        end
                        aluOr: begin
                                y = a | b;
                        end
                        aluSub: begin
                                y = a - b;
                        end
                        aluXor: begin
                                y = a ^ b;
                        end
                        default: begin
                                // pass-B also for unused codes
                                y = b;
                        end
                endcase
        end

endmodule

`default_nettype wire

// ==== rtl/execUnit/execStage.sv ====
`default_nettype none

module execStage (
        input  coreTypes_pkg::execEntry_t ex,
        input  logic                      wbValid,
        input  coreTypes_pkg::wbEntry_t   wb,
        output coreTypes_pkg::wbEntry_t   res
);
        import coreTypes_pkg::*;

        logic                   fwdA;
        logic                   fwdB;
        logic [dataWidth-1:0]   opA;
        logic [dataWidth-1:0]   regB;
        logic [dataWidth-1:0]   immExt;
        logic [dataWidth-1:0]   opB;
        logic [dataWidth-1:0]   aluY;
        logic [dataWidth-1:0]   shiftY;
        logic [3:0]             shAmt;
        logic [2*dataWidth-1:0] rotWide;

        // bypass from the instruction one ahead
        assign fwdA = wbValid && wb.regWrite && (wb.rd == ex.rs);
        assign fwdB = wbValid && wb.regWrite && (wb.rd == ex.rt);
        assign opA  = fwdA ? wb.result : ex.opA;
        assign regB = fwdB ? wb.result : ex.opB;

        assign immExt = ex.ctrl.immSigned ?
                        {{(dataWidth-immWidth){ex.imm[immWidth-1]}}, ex.imm} :
                        {{(dataWidth-immWidth){1'b0}}, ex.imm};
        assign opB    = ex.ctrl.immSel ? immExt : regB;

        aluUnit uAlu (
                .aluOp(ex.ctrl.aluOp),
                .a    (opA),
                .b    (opB),
                .y    (aluY)
        );

        assign shAmt   = opB[3:0];
        assign rotWide = {opA, opA} << shAmt;   // upper half is the rotate

        always_comb begin
                case (ex.ctrl.bsOp)
                        bsShl:   shiftY = opA << shAmt;
                        bsShr:   shiftY = opA >> shAmt;
                        bsSra:   shiftY = $signed(opA) >>> shAmt;
                        bsRol:   shiftY = rotWide[2*dataWidth-1 -: dataWidth];
                        default: shiftY = opA;
                endcase
        end

        assign res.regWrite = ex.ctrl.regWrite;
        assign res.rd       = ex.rd;
        assign res.result   = (ex.ctrl.bsOp != bsNone) ? shiftY : aluY;

endmodule

`default_nettype wire

// ==== rtl/miniCore.sv ====
`default_nettype none

module miniCore (
        input  logic                                   clk,
        input  logic                                   rstN,
        input  logic                                   take,
        input  coreTypes_pkg::instr_t                  instr,
        output logic                                   wbValid,
        output logic [coreTypes_pkg::regAddrWidth-1:0] wbDest,
        output logic [coreTypes_pkg::dataWidth-1:0]    wbData,
        output logic                                   halted
);
        import coreTypes_pkg::*;

        ctrlWord_t            decCtrl;
        execEntry_t           decEntry;
        execEntry_t           exEntry;
        wbEntry_t             exResult;
        wbEntry_t             wbEntry;
        logic                 accept;
        logic                 exValid;
        logic                 wbStageValid;
        logic                 regWrEn;
        logic [dataWidth-1:0] rdDataA;
        logic [dataWidth-1:0] rdDataB;

        assign accept = take & ~halted;

        controlCore uDecode (.opcode(instr.opcode), .ctrl(decCtrl));

        regBank uRegs (
                .clk    (clk),
                .rstN   (rstN),
                .wrEn   (regWrEn),
                .wrAddr (wbEntry.rd),
                .rdAddrA(instr.rs),
                .rdAddrB(instr.rt),
                .wrData (wbEntry.result),
                .rdDataA(rdDataA),
                .rdDataB(rdDataB)
        );

        always_comb begin
                decEntry               = '0;
                decEntry.ctrl          = decCtrl;
                decEntry.ctrl.regWrite = decCtrl.regWrite & decCtrl.enable;
                decEntry.rd            = instr.rd;
                decEntry.rs            = instr.rs;
                decEntry.rt            = instr.rt;
                decEntry.imm           = {instr.rs, instr.rt};   // low six bits
                decEntry.opA           = rdDataA;
                decEntry.opB           = rdDataB;
        end

        stageReg #(.payload_t(execEntry_t)) uExReg (
                .clk(clk), .rstN(rstN), .load(accept),
                .dIn(decEntry), .valid(exValid), .q(exEntry)
        );

        execStage uExec (.ex(exEntry), .wbValid(wbStageValid), .wb(wbEntry), .res(exResult));

        stageReg #(.payload_t(wbEntry_t)) uWbReg (
                .clk(clk), .rstN(rstN), .load(exValid),
                .dIn(exResult), .valid(wbStageValid), .q(wbEntry)
        );

        assign regWrEn = wbStageValid & wbEntry.regWrite;
        assign wbValid = regWrEn;
        assign wbDest  = wbEntry.rd;
        assign wbData  = wbEntry.result;

        // sticky until reset
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN)
                        halted <= 1'b0;
                else if (accept && !decCtrl.enable)
                        halted <= 1'b1;
        end

endmodule

`default_nettype wire

// ==== test/miniCore_asserts.sv ====
`default_nettype none

module miniCore_asserts (
        input logic clk,
        input logic rstN,
        input logic accept,
        input logic halted,
        input logic wbValid
);

        resetQuiet: assert property (@(posedge clk) !rstN |-> !wbValid)
                else $error("wbValid high while in reset");

        haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
                else $error("halted fell without a reset");

        // every writeback traces back to a take two edges earlier
        wbFromTake: assert property (@(posedge clk) disable iff (!rstN)
                        wbValid |-> $past(accept, 2))
                else $error("writeback without an accepted take two cycles before");

endmodule

bind miniCore miniCore_asserts uAsserts (
        .clk(clk), .rstN(rstN), .accept(accept), .halted(halted), .wbValid(wbValid)
);

`default_nettype wire

// ==== test/miniCore_tb.sv ====
`default_nettype none

module miniCore_tb;
        import coreTypes_pkg::*;

        logic                    clk;
        logic                    rstN;
        logic                    take;
        instr_t                  instr;
        logic                    wbValid;
        logic [regAddrWidth-1:0] wbDest;
        logic [dataWidth-1:0]    wbData;
        logic                    halted;

        logic [dataWidth-1:0] model [numRegs];   // architectural register state
        wbEntry_t             expQ [$];
        logic                 modelHalted;
        logic [31:0]          lcgState;
        logic [opWidth-1:0]   opPool [20];
        logic [opWidth-1:0]   regOps [5];
        logic [opWidth-1:0]   shiftOps [7];

        miniCore UUT (
                .clk(clk), .rstN(rstN), .take(take), .instr(instr),
                .wbValid(wbValid), .wbDest(wbDest), .wbData(wbData), .halted(halted)
        );

        always #5 clk = ~clk;

        function automatic logic [31:0] nextRand();
                lcgState = lcgState * 32'd1103515245 + 32'd12345;
                return lcgState;
        endfunction

        // expected writeback of one instruction per the opcode table
        function automatic wbEntry_t refExec(input instr_t ins, input logic [dataWidth-1:0] a,
                                             input logic [dataWidth-1:0] b);
                wbEntry_t             r;
                logic [dataWidth-1:0] immZ;
                logic [dataWidth-1:0] immS;
                logic [3:0]           amt;
                immZ       = {10'b0, ins.rs, ins.rt};
                immS       = {{10{ins.rs[2]}}, ins.rs, ins.rt};
                amt        = b[3:0];
                r          = '0;
                r.regWrite = 1'b1;
                r.rd       = ins.rd;
                case (ins.opcode)
                        opShlI:  r.result = a << immZ[3:0];
                        opShrI:  r.result = a >> immZ[3:0];
                        opSraI:  r.result = $signed(a) >>> immZ[3:0];
                        opAdd:   r.result = a + b;
                        opSub:   r.result = a - b;
                        opAddI:  r.result = a + immZ;
                        opSubI:  r.result = a - immZ;
                        opLoadI: r.result = immZ;
                        opAddIS: r.result = a + immS;
                        opOr:    r.result = a | b;
                        opXor:   r.result = a ^ b;
                        opShl:   r.result = a << amt;
                        opShr:   r.result = a >> amt;
                        opSra:   r.result = $signed(a) >>> amt;
                        opAnd:   r.result = a & b;
                        opRol:   r.result = (a << amt) | (a >> (5'd16 - 5'(amt)));
                        default: r.regWrite = 1'b0;   // cmp, halt and unknown ops
                endcase
                return r;
        endfunction

        task automatic abortRun(input string why);
                $display("%s", why);
                $display("Testbench failed");
                $fatal(1, "simulation stopped");
        endtask

        task automatic compareValue(input string name, input logic [dataWidth-1:0] got,
                                    input logic [dataWidth-1:0] exp);
                if (got !== exp)
                        abortRun($sformatf("FAIL %s got %h expected %h", name, got, exp));
        endtask

        task automatic issue(input instr_t ins);
                wbEntry_t expEntry;
                @(posedge clk);
                #1;
                take  = 1'b1;
                instr = ins;
                if (!modelHalted) begin
                        expEntry = refExec(ins, model[ins.rs], model[ins.rt]);
                        if (expEntry.regWrite) begin
                                model[expEntry.rd] = expEntry.result;
                                expQ.push_back(expEntry);
                        end
                        if (ins.opcode == opHalt)
                                modelHalted = 1'b1;
                end
        endtask

        task automatic drain();
                int waited;
                @(posedge clk);
                #1;
                take   = 1'b0;
                waited = 0;
                while (expQ.size() != 0 && waited < 20) begin
                        @(posedge clk);
                        waited++;
                end
                if (expQ.size() != 0)
                        abortRun("timeout waiting for the expected writebacks");
        endtask

        // writeback checker
        initial begin
                wbEntry_t expEntry;
                forever begin
                        @(negedge clk);
                        if (rstN && wbValid) begin
                                if (expQ.size() == 0)
                                        abortRun("writeback seen while none was expected");
                                expEntry = expQ.pop_front();
                                compareValue("wbDest", dataWidth'(wbDest), dataWidth'(expEntry.rd));
                                compareValue("wbData", wbData, expEntry.result);
                        end
                end
        end

        initial begin
                int                      waited;
                logic [31:0]             r;
                logic [regAddrWidth-1:0] prev1;
                logic [regAddrWidth-1:0] prev2;
                clk         = 1'b0;
                rstN        = 1'b0;
                take        = 1'b0;
                instr       = '0;
                modelHalted = 1'b0;
                lcgState    = 32'd61;
                model       = '{default: '0};
                opPool      = '{opShlI, opShrI, opSraI, opAdd, opSub, opAddI, opSubI, opLoadI,
                                opCmp, opAddIS, opOr, opXor, opShl, opShr, opSra, opAnd, opRol,
                                7'd11, 7'd42, 7'd127};
                regOps      = '{opAdd, opSub, opAnd, opOr, opXor};
                shiftOps    = '{opShlI, opShrI, opSraI, opShl, opShr, opSra, opRol};
                repeat (3) @(posedge clk);
                #1 rstN = 1'b1;

                repeat (10) begin   // quiet after reset
                        @(negedge clk);
                        compareValue("wbValid", dataWidth'(wbValid), '0);
                        compareValue("halted", dataWidth'(halted), '0);
                end

                for (int i = 0; i < numRegs; i++) begin
                        r = nextRand();
                        issue({opLoadI, 3'(i), r[21:16]});
                end
                for (int k = 0; k < 15; k++) begin
                        r = nextRand();
                        issue({regOps[3'(k % 5)], r[18:16], r[21:19], r[24:22]});
                end
                drain();

                // each op reads the two results just ahead of it
                prev1 = 3'd1;
                prev2 = 3'd2;
                for (int k = 0; k < 30; k++) begin
                        r = nextRand();
                        issue({regOps[3'(k % 5)], r[18:16], prev1, prev2});
                        prev2 = prev1;
                        prev1 = r[18:16];
                end
                drain();

                for (int k = 0; k < 21; k++) begin
                        r = nextRand();
                        issue({opAddI, r[18:16], 1'b1, r[21:17]});
                        issue({opAddIS, r[18:16], 1'b1, r[21:17]});
                        issue({opSubI, r[24:22], r[30:25]});
                        issue({shiftOps[3'(k % 7)], r[18:16], r[21:19], r[24:22]});
                end
                drain();

                issue({opCmp, 9'h0ab});
                issue({7'd11, 9'h1c5});
                issue({7'd127, 9'h0f3});
                issue({opAdd, 3'd1, 3'd2, 3'd3});
                drain();

                for (int k = 0; k < 300; k++) begin
                        r = nextRand();
                        issue({opPool[r[20:16] % 5'd20], r[31:23]});
                end
                issue({opHalt, 9'd0});
                waited = 0;
                while (!halted && waited < 10) begin
                        @(negedge clk);
                        waited++;
                end
                if (!halted)
                        abortRun("halted did not rise after the halt instruction");
                for (int k = 0; k < 8; k++) begin
                        r = nextRand();
                        issue({opLoadI, r[18:16], r[24:19]});   // must be ignored
                end
                drain();
                repeat (5) @(negedge clk);
                compareValue("halted", dataWidth'(halted), 16'd1);

                $display("Testbench passed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== miniCore.f ====
common/coreTypes_pkg.sv
rtl/controlCore.sv
rtl/stageReg.sv
rtl/regBank.sv
rtl/execUnit/aluUnit.sv
rtl/execUnit/execStage.sv
rtl/miniCore.sv
test/miniCore_asserts.sv
test/miniCore_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= miniCore_tb
FILELIST  ?= miniCore.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
